// File: filelist.f
rtl/inject_pkg.sv
rtl/mem_wr_if.sv
rtl/inject_sequencer.sv
rtl/mem_slot_writer.sv
rtl/autotype_run.sv
rtl/prg_inject_top.sv
dv/tb_clock_gen.sv
dv/tb_prg_inject.sv

// File: Makefile
# Verilator build and run of the PRG injection testbench

VERILATOR ?= verilator
TOP       ?= tb_prg_inject
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_prg_inject.sv
/* One PRG download with random bus slots, then the pointer sweep and the autotype keys.
   The run stops at the first error. */
`default_nettype none

module tb_prg_inject;
	timeunit 1ns;
	timeprecision 1ps;

	import inject_pkg::*;

	localparam int STEP_CYCLES = 20;
	localparam int PAYLOAD_LEN = 40;
	localparam int HOLD_INDEX  = 20;
	localparam int HOLD_CYCLES = 50;
	localparam int WAIT_LIMIT  = 2000;
	localparam int TYPE_LIMIT  = 8000;
	localparam logic [MEM_ADDR_W-1:0] LOAD_ADDR = 16'h0801;
	localparam logic [7:0] KEY_SEQ [7] = '{SC_LSHIFT, SC_HOME, SC_LSHIFT, SC_R, SC_U, SC_N,
		SC_RETURN};

	logic                   clk_sys;
	logic                   reset_n;
	logic                   ioctl_download_i;
	logic                   ioctl_wr_i;
	logic [HOST_ADDR_W-1:0] ioctl_addr_i;
	logic [DATA_W-1:0]      ioctl_data_i;
	logic                   ioctl_wait_o;
	logic                   io_cycle_i;
	logic                   mem_we_o;
	logic [MEM_ADDR_W-1:0]  mem_addr_o;
	logic [DATA_W-1:0]      mem_data_o;
	logic [KEY_W-1:0]       host_key_i;
	logic [KEY_W-1:0]       key_o;

	integer seed = 17;
	logic   hold_bus = 1'b0;
	int     write_count = 0;

	// Expected memory writes in issue order
	logic [MEM_ADDR_W-1:0] exp_addr [$];
	logic [DATA_W-1:0]     exp_data [$];

	tb_clock_gen i_clock_gen (
		.clk_sys (clk_sys),
		.reset_n (reset_n)
	);

	prg_inject_top #(
		.step_cycles (STEP_CYCLES)
	) i_prg_inject_top (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.ioctl_wait_o     (ioctl_wait_o),
		.io_cycle_i       (io_cycle_i),
		.mem_we_o         (mem_we_o),
		.mem_addr_o       (mem_addr_o),
		.mem_data_o       (mem_data_o),
		.host_key_i       (host_key_i),
		.key_o            (key_o)
	);

	task automatic report_error(input string msg);
		$display("** Error @ %0t: %s", $time, msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped on failure");
	endtask

	function automatic void expect_write(input logic [MEM_ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endfunction

	// ==========================================================================
	// Checks
	// ==========================================================================
	a_reset_quiet: assert property (@(posedge clk_sys)
		!reset_n |=> !mem_we_o && !ioctl_wait_o)
		else report_error("mem_we_o or ioctl_wait_o high during reset");

	// A strobe only ever serves a pending request
	a_we_with_wait: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_we_o |-> ioctl_wait_o)
		else report_error("mem_we_o high without a pending write");

	always @(negedge clk_sys) begin
		if (reset_n === 1'b1 && mem_we_o === 1'b1) begin
			write_count++;
			if (exp_addr.size() == 0) begin
				report_error($sformatf("unexpected write %h <= %h", mem_addr_o, mem_data_o));
			end else begin
				assert (mem_addr_o == exp_addr[0] && mem_data_o == exp_data[0]) else
					report_error($sformatf("write %h <= %h, expected %h <= %h",
						mem_addr_o, mem_data_o, exp_addr[0], exp_data[0]));
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
			end
		end
	end

	// ==========================================================================
	// Stimulus
	// ==========================================================================
	// Random bus ownership that is forced high while the host is held off
	initial begin
		io_cycle_i = 1'b0;
		forever begin
			@(posedge clk_sys);
			#1;
			io_cycle_i = hold_bus ? 1'b1 : 1'($random(seed));
		end
	end

	task automatic send_byte(input int offset, input logic [DATA_W-1:0] value);
		ioctl_addr_i = HOST_ADDR_W'(offset);
		ioctl_data_i = value;
		ioctl_wr_i   = 1'b1;
		@(posedge clk_sys);
		#1;
		ioctl_wr_i = 1'b0;
	endtask

	task automatic wait_ready();
		int t;
		t = 0;
		while (ioctl_wait_o && t < WAIT_LIMIT) begin
			@(posedge clk_sys);
			#1;
			t++;
		end
		if (ioctl_wait_o) begin
			report_failure("Timeout: ioctl_wait_o stayed high, write never served");
		end
	endtask

	task automatic check_passthrough(input int count);
		logic [KEY_W-1:0] key;
		for (int i = 0; i < count; i++) begin
			key = KEY_W'($random(seed));
			host_key_i = key;
			@(posedge clk_sys);
			#1;
			assert (key_o == key) else
				report_error($sformatf("key_o %h, expected host key %h", key_o, key));
		end
	endtask

	// Pointer locations in ascending address order
	task automatic expect_sweep(input logic [MEM_ADDR_W-1:0] end_addr);
		expect_write(16'h002B, 8'h01);
		expect_write(16'h002C, 8'h08);
		for (int i = 0; i < 3; i++) begin
			expect_write(MEM_ADDR_W'(16'h002D + 2 * i), end_addr[7:0]);
			expect_write(MEM_ADDR_W'(16'h002E + 2 * i), end_addr[15:8]);
		end
		expect_write(16'h00AC, 8'h00);
		expect_write(16'h00AD, 8'h00);
		expect_write(16'h00AE, end_addr[7:0]);
		expect_write(16'h00AF, end_addr[15:8]);
	endtask

	// Collects scan code changes up to the return to the host key
	task automatic watch_autotype();
		logic [7:0] prev;
		logic [7:0] seen [$];
		int         t;
		prev = key_o[7:0];
		t    = 0;
		while (seen.size() < 8 && t < TYPE_LIMIT) begin
			@(posedge clk_sys);
			#1;
			t++;
			if (key_o[7:0] != prev) begin
				prev = key_o[7:0];
				seen.push_back(prev);
			end
		end
		if (seen.size() < 8) begin
			report_failure("Timeout: autotype sequence did not complete");
		end
		for (int i = 0; i < 7; i++) begin
			assert (seen[i] == KEY_SEQ[i]) else
				report_error($sformatf("autotype key %0d is %h, expected %h",
					i, seen[i], KEY_SEQ[i]));
		end
		assert (key_o == host_key_i) else
			report_error($sformatf("key_o %h after autotype, expected %h", key_o, host_key_i));
	endtask

	initial begin : main_flow
		logic [DATA_W-1:0] value;
		int                t;
		ioctl_download_i = 1'b0;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		ioctl_data_i     = '0;
		host_key_i       = '0;

		t = 0;
		while (reset_n !== 1'b1 && t < 100) begin
			@(posedge clk_sys);
			t++;
		end
		if (reset_n !== 1'b1) begin
			report_failure("Timeout: reset_n was never released");
		end
		@(posedge clk_sys);
		#1;
		check_passthrough(8);
		host_key_i = '0;
		@(posedge clk_sys);
		#1;

		// PRG header then payload
		ioctl_download_i = 1'b1;
		send_byte(0, LOAD_ADDR[7:0]);
		wait_ready();
		send_byte(1, LOAD_ADDR[15:8]);
		wait_ready();
		for (int n = 0; n < PAYLOAD_LEN; n++) begin
			value = DATA_W'($random(seed));
			expect_write(LOAD_ADDR + MEM_ADDR_W'(n), value);
			if (n == HOLD_INDEX) begin
				hold_bus = 1'b1;
				repeat (2) begin
					@(posedge clk_sys);
				end
				#1;
				send_byte(n + 2, value);
				for (int i = 0; i < HOLD_CYCLES; i++) begin
					assert (!mem_we_o && ioctl_wait_o) else
						report_error("no back-pressure while the CPU owns the bus");
					@(posedge clk_sys);
					#1;
				end
				hold_bus = 1'b0;
			end else begin
				send_byte(n + 2, value);
			end
			wait_ready();
		end

		expect_sweep(LOAD_ADDR + MEM_ADDR_W'(PAYLOAD_LEN));
		ioctl_download_i = 1'b0;
		watch_autotype();

		assert (exp_addr.size() == 0) else
			report_error($sformatf("%0d writes seen, %0d expected writes missing",
				write_count, exp_addr.size()));
		check_passthrough(8);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
/* Free-running clk_sys at 10 ns. reset_n is released 1 ns after the last reset edge. */
`default_nettype none

module tb_clock_gen #(
	parameter int reset_cycles = 16
) (
	output logic clk_sys,
	output logic reset_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk_sys = 1'b0;
		forever begin
			#5 clk_sys = ~clk_sys;
		end
	end

	initial begin
		reset_n = 1'b0;
		repeat (reset_cycles) begin
			@(posedge clk_sys);
		end
		#1 reset_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: rtl/prg_inject_top.sv
/* PRG injection top. ioctl_wait_o stays high while a byte waits for a bus slot,
   and the host must not strobe ioctl_wr_i then. */
`default_nettype none

module prg_inject_top #(
	parameter int unsigned step_cycles = inject_pkg::KEY_STEP_CYCLES
) (
	input  logic                               clk_sys,
	input  logic                               reset_n,

	// Host download stream
	input  logic                               ioctl_download_i,
	input  logic                               ioctl_wr_i,
	input  logic [inject_pkg::HOST_ADDR_W-1:0] ioctl_addr_i,
	input  logic [inject_pkg::DATA_W-1:0]      ioctl_data_i,
	output logic                               ioctl_wait_o,

	// C64 memory bus
	input  logic                               io_cycle_i,
	output logic                               mem_we_o,
	output logic [inject_pkg::MEM_ADDR_W-1:0]  mem_addr_o,
	output logic [inject_pkg::DATA_W-1:0]      mem_data_o,

	// Keyboard
	input  logic [inject_pkg::KEY_W-1:0]       host_key_i,
	output logic [inject_pkg::KEY_W-1:0]       key_o
);

	logic inject_done;

	mem_wr_if wr_bus ();

	inject_sequencer i_inject_sequencer (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.wr               (wr_bus.requester),
		.inject_done_o    (inject_done)
	);

	mem_slot_writer i_mem_slot_writer (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.io_cycle_i (io_cycle_i),
		.wr         (wr_bus.server),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

	autotype_run #(
		.step_cycles (step_cycles)
	) i_autotype_run (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.inject_done_i (inject_done),
		.host_key_i    (host_key_i),
		.key_o         (key_o)
	);

	// Host back-pressure follows the pending write
	assign ioctl_wait_o = wr_bus.req;

endmodule

`default_nettype wire

// File: rtl/autotype_run.sv
/* Types SHIFT+HOME then RUN RETURN after injection, one step per step_cycles+1 clocks.
   Host keys are ignored while the sequence runs. */
`default_nettype none

module autotype_run #(
	parameter int unsigned step_cycles = inject_pkg::KEY_STEP_CYCLES
) (
	input  logic                         clk_sys,
	input  logic                         reset_n,
	input  logic                         inject_done_i,
	input  logic [inject_pkg::KEY_W-1:0] host_key_i,
	output logic [inject_pkg::KEY_W-1:0] key_o
);
	import inject_pkg::*;

	// Step 0 is idle and steps 1 to 15 run the sequence
	logic [3:0]                         act;
	logic [$clog2(step_cycles + 1)-1:0] timer;
	logic                               step_due;
	logic [DATA_W:0]                    step_key;

	assign step_due = (timer == $bits(timer)'(step_cycles));
	assign step_key = autotype_key(act);

	// ==========================================================================
	// Step sequencer
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			act   <= '0;
			timer <= '0;
			key_o <= '0;
		end else begin
			if (act != 4'd0) begin
				if (step_due) begin
					timer <= '0;
					if (act == 4'd15) begin
						act <= 4'd0;
					end else begin
						act <= act + 4'd1;
					end
					if (step_key[DATA_W]) begin
						key_o <= KEY_W'(step_key[DATA_W-1:0]);
					end
					// Odd steps press and even steps release
					key_o[9] <= act[0];
				end else begin
					timer <= timer + 1'b1;
				end
			end else begin
				timer <= '0;
				key_o <= host_key_i;
			end

			// A new injection restarts the sequence
			if (inject_done_i) begin
				act <= 4'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/mem_slot_writer.sv
/* Serves one pending write per falling edge of io_cycle_i. A request that
   arrives while io_cycle_i is already low waits for the next edge. */
`default_nettype none

module mem_slot_writer (
	input  logic                              clk_sys,
	input  logic                              reset_n,
	input  logic                              io_cycle_i,
	mem_wr_if.server                          wr,
	output logic                              mem_we_o,
	output logic [inject_pkg::MEM_ADDR_W-1:0] mem_addr_o,
	output logic [inject_pkg::DATA_W-1:0]     mem_data_o
);

	logic io_cycle_d;
	logic slot_edge;
	logic serve;

	// CPU has just released the bus
	assign slot_edge = io_cycle_d && !io_cycle_i;
	assign serve     = slot_edge && wr.req;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_cycle_d <= 1'b0;
			mem_we_o   <= 1'b0;
		end else begin
			io_cycle_d <= io_cycle_i;
			mem_we_o   <= serve;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (serve) begin
			mem_addr_o <= wr.addr;
			mem_data_o <= wr.data;
		end
	end

	// Ack coincides with the write strobe
	assign wr.ack = mem_we_o;

	// One write per slot
	a_we_single: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_we_o |=> !mem_we_o);

endmodule

`default_nettype wire

// File: rtl/inject_sequencer.sv
/* PRG header parse, byte stream writes and BASIC pointer sweep after the download.
   The host must hold off ioctl_wr_i while a write is pending. */
`default_nettype none

module inject_sequencer (
	input  logic                               clk_sys,
	input  logic                               reset_n,
	input  logic                               ioctl_download_i,
	input  logic                               ioctl_wr_i,
	input  logic [inject_pkg::HOST_ADDR_W-1:0] ioctl_addr_i,
	input  logic [inject_pkg::DATA_W-1:0]      ioctl_data_i,
	mem_wr_if.requester                        wr,
	output logic                               inject_done_o
);
	import inject_pkg::*;

	// Running load address, reused as sweep address once the stream ends
	logic [MEM_ADDR_W-1:0] cur_addr;
	logic [MEM_ADDR_W-1:0] end_addr;
	logic                  download_d;
	logic                  sweep;

	logic                  stream_wr;
	logic                  hdr_lo;
	logic                  hdr_hi;
	logic                  data_wr;
	logic                  sweep_start;
	logic                  sweep_step;
	logic                  sweep_end;
	logic                  load_req;

	logic                  ptr_hit;
	logic [DATA_W-1:0]     ptr_data;

	// ==========================================================================
	// Stream decode
	// ==========================================================================
	assign stream_wr   = ioctl_download_i && ioctl_wr_i;
	assign hdr_lo      = stream_wr && (ioctl_addr_i == '0);
	assign hdr_hi      = stream_wr && (ioctl_addr_i == HOST_ADDR_W'(1));
	assign data_wr     = stream_wr && (ioctl_addr_i > HOST_ADDR_W'(1));
	assign sweep_start = download_d && !ioctl_download_i;

	// Sweep only advances while no write is outstanding
	assign sweep_step  = sweep && !wr.req && (cur_addr != ZP_LAST);
	assign sweep_end   = sweep && !wr.req && (cur_addr == ZP_LAST);
	assign load_req    = data_wr || (sweep_step && ptr_hit);

	// ==========================================================================
	// Pointer table
	// ==========================================================================
	always_comb begin
		ptr_hit  = 1'b1;
		ptr_data = '0;
		case (cur_addr[7:0])
			PTR_TXT_LO: ptr_data = BASIC_TXT_START[7:0];
			PTR_TXT_HI: ptr_data = BASIC_TXT_START[15:8];
			PTR_SAVE_LO, PTR_SAVE_HI: ptr_data = '0;
			PTR_VAR_LO, PTR_ARY_LO, PTR_STR_LO, PTR_LEND_LO: ptr_data = end_addr[7:0];
			PTR_VAR_HI, PTR_ARY_HI, PTR_STR_HI, PTR_LEND_HI: ptr_data = end_addr[15:8];
			default: ptr_hit = 1'b0;
		endcase
	end

	// ==========================================================================
	// Control
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			download_d    <= 1'b0;
			sweep         <= 1'b0;
			inject_done_o <= 1'b0;
			wr.req        <= 1'b0;
		end else begin
			download_d    <= ioctl_download_i;
			inject_done_o <= 1'b0;

			if (wr.ack) begin
				wr.req <= 1'b0;
			end
			if (load_req) begin
				wr.req <= 1'b1;
			end

			if (sweep_start) begin
				sweep <= 1'b1;
			end
			if (sweep_end) begin
				sweep         <= 1'b0;
				inject_done_o <= 1'b1;
			end
		end
	end

	// ==========================================================================
	// Address and data path
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		// Header bytes give the load address, low byte first
		if (hdr_lo) begin
			cur_addr[7:0] <= ioctl_data_i;
			end_addr[7:0] <= ioctl_data_i;
		end
		if (hdr_hi) begin
			cur_addr[15:8] <= ioctl_data_i;
			end_addr[15:8] <= ioctl_data_i;
		end

		if (load_req) begin
			wr.addr <= cur_addr;
			wr.data <= sweep ? ptr_data : ioctl_data_i;
		end

		if (data_wr || sweep_step) begin
			cur_addr <= cur_addr + 1'b1;
		end
		if (data_wr) begin
			end_addr <= end_addr + 1'b1;
		end

		if (sweep_start) begin
			cur_addr <= '0;
		end
	end

	// A waiting write keeps its address and data until the slot writer takes it
	a_req_stable: assert property (@(posedge clk_sys) disable iff (!reset_n)
		wr.req && !wr.ack |=> wr.req && $stable(wr.addr) && $stable(wr.data));

endmodule

`default_nettype wire

// File: rtl/mem_wr_if.sv
/* One pending memory write. req holds addr and data stable until the one-cycle ack
   and drops in the cycle after it. */
`default_nettype none

interface mem_wr_if;
	import inject_pkg::*;

	logic                  req;
	logic [MEM_ADDR_W-1:0] addr;
	logic [DATA_W-1:0]     data;
	logic                  ack;

	// Sequencer side
	modport requester (
		output req,
		output addr,
		output data,
		input  ack
	);

	// Slot writer side
	modport server (
		input  req,
		input  addr,
		input  data,
		output ack
	);

endinterface

`default_nettype wire

// File: rtl/inject_pkg.sv
/* Shared widths, C64 zero-page pointer map and autotype key table for PRG injection.
   Pointer locations follow the stock BASIC V2 layout. No other ROM is supported. */
`default_nettype none

package inject_pkg;

	// ==========================================================================
	// Bus and stream widths
	// ==========================================================================
	localparam int MEM_ADDR_W  = 16;
	localparam int DATA_W      = 8;
	localparam int HOST_ADDR_W = 25;
	// PS/2 key word with scan code in 7..0 and press flag in bit 9
	localparam int KEY_W       = 11;

	// ==========================================================================
	// BASIC pointer sweep
	// ==========================================================================
	localparam logic [MEM_ADDR_W-1:0] ZP_LAST         = 16'h0100;
	localparam logic [MEM_ADDR_W-1:0] BASIC_TXT_START = 16'h0801;

	// Start of BASIC text and SAVE start keep their power-on values
	localparam logic [7:0] PTR_TXT_LO  = 8'h2B;
	localparam logic [7:0] PTR_TXT_HI  = 8'h2C;
	localparam logic [7:0] PTR_SAVE_LO = 8'hAC;
	localparam logic [7:0] PTR_SAVE_HI = 8'hAD;

	// Variables, arrays, strings and load end all point past the program
	localparam logic [7:0] PTR_VAR_LO  = 8'h2D;
	localparam logic [7:0] PTR_VAR_HI  = 8'h2E;
	localparam logic [7:0] PTR_ARY_LO  = 8'h2F;
	localparam logic [7:0] PTR_ARY_HI  = 8'h30;
	localparam logic [7:0] PTR_STR_LO  = 8'h31;
	localparam logic [7:0] PTR_STR_HI  = 8'h32;
	localparam logic [7:0] PTR_LEND_LO = 8'hAE;
	localparam logic [7:0] PTR_LEND_HI = 8'hAF;

	// ==========================================================================
	// Autotype
	// ==========================================================================
	localparam int unsigned KEY_STEP_CYCLES = 640000;

	localparam logic [7:0] SC_LSHIFT = 8'h12;
	localparam logic [7:0] SC_HOME   = 8'h6C;
	localparam logic [7:0] SC_R      = 8'h2D;
	localparam logic [7:0] SC_U      = 8'h3C;
	localparam logic [7:0] SC_N      = 8'h31;
	localparam logic [7:0] SC_RETURN = 8'h5A;

	// Scan code of an autotype step; MSB set when the step carries a code
	function automatic logic [DATA_W:0] autotype_key(input logic [3:0] step);
		case (step)
			4'd1:    return {1'b1, SC_LSHIFT};
			4'd2:    return {1'b1, SC_HOME};
			4'd5:    return {1'b1, SC_LSHIFT};
			4'd7:    return {1'b1, SC_R};
			4'd9:    return {1'b1, SC_U};
			4'd11:   return {1'b1, SC_N};
			4'd13:   return {1'b1, SC_RETURN};
			default: return '0;
		endcase
	endfunction

endpackage

`default_nettype wire
